// ==== pma_access_pkg.sv ====
package pma_access_pkg;

  // Access width of a load, store or fetch
  // Also the widest access a region allows
  typedef enum logic [1:0] {
    byte_acc       = 2'd0,
    half_acc       = 2'd1,
    word_acc       = 2'd2,
    // Never stored, WARL maps it to word_acc
    acc_width_rsvd = 2'd3
  } acc_width_t;

  // Exception cause codes from the privileged spec
  // Only the access fault subset is raised here
  typedef enum logic [4:0] {
    instr_access_fault = 5'd1,
    load_access_fault  = 5'd5,
    store_access_fault = 5'd7
  } exc_cause_t;

endpackage

// ==== pma_cfg_pkg.sv ====
package pma_cfg_pkg;

  // Reservability of LR/SC in a region
  typedef enum logic [1:0] {
    rsrv_none,
    rsrv_strong,
    rsrv_eventual,
    // Never stored, WARL maps it to rsrv_none
    rsrv_rsvd
  } rsrv_t;

  // AMO support class
  typedef enum logic [1:0] {
    amo_none,
    amo_swap,
    amo_logical,
    amo_arith
  } amo_t;

  // One half-region configuration, MSB first
  typedef struct packed {
    logic [2:0]               rsvd;
    logic                     w;
    logic                     r;
    logic                     x;
    pma_access_pkg::acc_width_t acc_width;
    // Stored only, not enforced
    logic                     idm;
    logic                     cache;
    logic                     coh;
    rsrv_t                    rsrv;
    amo_t                     amo;
    // 1 = memory, 0 = I/O
    logic                     mem;
  } pma_cfg_t;

  // One CSR, upper half covers the upper 128 MB
  typedef struct packed {
    pma_cfg_t cfg_1;
    pma_cfg_t cfg_0;
  } pma_reg_t;

  // Boot ROM, read and execute only
  localparam pma_cfg_t ROM_CFG = '{rsvd: 3'b000, w: 1'b0, r: 1'b1, x: 1'b1,
    acc_width: pma_access_pkg::word_acc, idm: 1'b1, cache: 1'b1, coh: 1'b1,
    rsrv: rsrv_eventual, amo: amo_none, mem: 1'b1};

  // Main memory, same as ROM plus write
  localparam pma_cfg_t RAM_CFG = '{rsvd: 3'b000, w: 1'b1, r: 1'b1, x: 1'b1,
    acc_width: pma_access_pkg::word_acc, idm: 1'b1, cache: 1'b1, coh: 1'b1,
    rsrv: rsrv_eventual, amo: amo_none, mem: 1'b1};

  // Device space, uncached and not idempotent
  localparam pma_cfg_t IO_CFG = '{rsvd: 3'b000, w: 1'b1, r: 1'b1, x: 1'b1,
    acc_width: pma_access_pkg::word_acc, idm: 1'b0, cache: 1'b0, coh: 1'b1,
    rsrv: rsrv_eventual, amo: amo_none, mem: 1'b0};

endpackage

// ==== pma_checker.sv ====
`timescale 1ns/1ps

`include "pma_defines.svh"

module pma_checker (
  input  pma_cfg_pkg::pma_reg_t [`PMA_NUM_REGS-1:0]  pma_regs_i,
  input  logic [31:0]                                daddr_i,
  input  logic                                       d_ren_i,
  input  logic                                       d_wen_i,
  input  pma_access_pkg::acc_width_t                 d_width_i,
  input  logic [31:0]                                iaddr_i,
  input  logic                                       i_xen_i,
  input  pma_access_pkg::acc_width_t                 i_width_i,
  output logic                                       l_fault_o,
  output logic                                       s_fault_o,
  output logic                                       i_fault_o,
  output logic [31:0]                                fault_addr_o
);

  pma_cfg_pkg::pma_reg_t d_reg;
  pma_cfg_pkg::pma_reg_t i_reg;
  pma_cfg_pkg::pma_cfg_t d_cfg;
  pma_cfg_pkg::pma_cfg_t i_cfg;
  logic                  d_width_bad;
  logic                  i_width_bad;
  logic                  l_raw;
  logic                  s_raw;
  logic                  i_raw;

  // Region lookup, data and fetch side independent
  assign d_reg = pma_regs_i[daddr_i[`PMA_REGION_MSB:`PMA_HALF_BIT+1]];
  assign i_reg = pma_regs_i[iaddr_i[`PMA_REGION_MSB:`PMA_HALF_BIT+1]];

  // Half select within the 256 MB region
  assign d_cfg = daddr_i[`PMA_HALF_BIT] ? d_reg.cfg_1 : d_reg.cfg_0;
  assign i_cfg = iaddr_i[`PMA_HALF_BIT] ? i_reg.cfg_1 : i_reg.cfg_0;

  // Wider than the region allows
  assign d_width_bad = (d_width_i > d_cfg.acc_width);
  assign i_width_bad = (i_width_i > i_cfg.acc_width);

  // Per-port violations before priority
  assign l_raw = d_ren_i && (!d_cfg.r || d_width_bad);
  assign s_raw = d_wen_i && (!d_cfg.w || d_width_bad);
  assign i_raw = i_xen_i && (!i_cfg.x || i_width_bad);

  // Load wins over store, store over fetch
  always_comb begin
    l_fault_o    = 1'b0;
    s_fault_o    = 1'b0;
    i_fault_o    = 1'b0;
    fault_addr_o = daddr_i;
    if (l_raw) begin
      l_fault_o = 1'b1;
    end else if (s_raw) begin
      s_fault_o = 1'b1;
    end else if (i_raw) begin
      i_fault_o    = 1'b1;
      // Fetch fault reports the PC
      fault_addr_o = iaddr_i;
    end
  end

endmodule

// ==== pma_csr_regs.sv ====
`timescale 1ns/1ps

`include "pma_defines.svh"

module pma_csr_regs (
  input  logic                                       CLK,
  input  logic                                       nRST,
  input  logic [11:0]                                csr_addr_i,
  input  logic                                       csr_wen_i,
  input  logic [31:0]                                csr_wdata_i,
  output logic                                       csr_ack_o,
  output logic [31:0]                                csr_rdata_o,
  output pma_cfg_pkg::pma_reg_t [`PMA_NUM_REGS-1:0]  pma_regs_o
);

  // Register index width from the low CSR address bits
  localparam int IDX_W = $clog2(`PMA_NUM_REGS);

  pma_cfg_pkg::pma_reg_t [`PMA_NUM_REGS-1:0] regs;
  pma_cfg_pkg::pma_reg_t                     wr_val;
  logic [IDX_W-1:0]                          wr_idx;
  logic                                      wr_en;

  // Reset map per register
  // Region 0 low half is boot ROM, rest of 0..7 is RAM, 8..15 is I/O
  function automatic pma_cfg_pkg::pma_reg_t reset_entry(input int idx);
    pma_cfg_pkg::pma_reg_t ent;
    if (idx == 0) begin
      ent.cfg_1 = pma_cfg_pkg::RAM_CFG;
      ent.cfg_0 = pma_cfg_pkg::ROM_CFG;
    end else if (idx < `PMA_NUM_REGS / 2) begin
      ent.cfg_1 = pma_cfg_pkg::RAM_CFG;
      ent.cfg_0 = pma_cfg_pkg::RAM_CFG;
    end else begin
      ent.cfg_1 = pma_cfg_pkg::IO_CFG;
      ent.cfg_0 = pma_cfg_pkg::IO_CFG;
    end
    return ent;
  endfunction

  // WARL fixup of one half on its own
  function automatic pma_cfg_pkg::pma_cfg_t warl_half(input pma_cfg_pkg::pma_cfg_t c);
    pma_cfg_pkg::pma_cfg_t s;
    s = c;
    if (c.rsrv == pma_cfg_pkg::rsrv_rsvd) begin
      s.rsrv = pma_cfg_pkg::rsrv_none;
    end
    if (c.acc_width == pma_access_pkg::acc_width_rsvd) begin
      s.acc_width = pma_access_pkg::word_acc;
    end
    return s;
  endfunction

  // Block select, ack is purely the address match
  assign csr_ack_o = (csr_addr_i[11:4] == `PMA_CSR_BASE);
  assign wr_en     = csr_wen_i && csr_ack_o;
  assign wr_idx    = csr_addr_i[IDX_W-1:0];

  // Sanitize both halves separately
  always_comb begin
    wr_val.cfg_1 = warl_half(pma_cfg_pkg::pma_cfg_t'(csr_wdata_i[31:16]));
    wr_val.cfg_0 = warl_half(pma_cfg_pkg::pma_cfg_t'(csr_wdata_i[15:0]));
  end

  // Register file, write visible on the next edge
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `PMA_NUM_REGS; i++) begin
        regs[i] <= reset_entry(i);
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_val;
    end
  end

  // Combinational read of the selected register
  assign csr_rdata_o = regs[wr_idx];
  assign pma_regs_o  = regs;

  // Write path must never leave a reserved encoding behind
  for (genvar g = 0; g < `PMA_NUM_REGS; g++) begin : g_warl_chk
    a_no_rsvd: assert property (@(posedge CLK) disable iff (!nRST)
      (regs[g].cfg_0.acc_width != pma_access_pkg::acc_width_rsvd) &&
      (regs[g].cfg_1.acc_width != pma_access_pkg::acc_width_rsvd) &&
      (regs[g].cfg_0.rsrv != pma_cfg_pkg::rsrv_rsvd) &&
      (regs[g].cfg_1.rsrv != pma_cfg_pkg::rsrv_rsvd));
  end

endmodule

// ==== pma_defines.svh ====
`ifndef PMA_DEFINES_SVH
`define PMA_DEFINES_SVH

// Upper CSR address field of the PMA block
// Gives CSR addresses BC0 to BCF
`define PMA_CSR_BASE 8'hBC

// One register per 256 MB region
`define PMA_NUM_REGS 16

// Address bits 31:28 pick the register
`define PMA_REGION_MSB 31

// Bit 27 picks the 128 MB half inside a region
// Region index LSB sits one above this bit
`define PMA_HALF_BIT 27

`endif

// ==== pma_fault_reporter.sv ====
`timescale 1ns/1ps

module pma_fault_reporter (
  input  logic                        CLK,
  input  logic                        nRST,
  input  logic                        l_fault_i,
  input  logic                        s_fault_i,
  input  logic                        i_fault_i,
  input  logic [31:0]                 fault_addr_i,
  output logic                        exc_valid_o,
  output pma_access_pkg::exc_cause_t  exc_cause_o,
  output logic [31:0]                 exc_tval_o
);

  logic                       any_fault;
  pma_access_pkg::exc_cause_t cause_nxt;

  assign any_fault = l_fault_i || s_fault_i || i_fault_i;

  // Cause encode, inputs already one-hot
  always_comb begin
    if (l_fault_i) begin
      cause_nxt = pma_access_pkg::load_access_fault;
    end else if (s_fault_i) begin
      cause_nxt = pma_access_pkg::store_access_fault;
    end else begin
      cause_nxt = pma_access_pkg::instr_access_fault;
    end
  end

  // One-cycle pulse per faulting cycle
  // Cause and tval hold until the next fault
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exc_valid_o <= 1'b0;
      exc_cause_o <= pma_access_pkg::exc_cause_t'(5'd0);
      exc_tval_o  <= 32'd0;
    end else begin
      exc_valid_o <= any_fault;
      if (any_fault) begin
        exc_cause_o <= cause_nxt;
        exc_tval_o  <= fault_addr_i;
      end
    end
  end

  // Core samples valid every cycle
  a_valid_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown(exc_valid_o));

  // Encoder above needs a single cause per cycle from the checker
  a_fault_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({l_fault_i, s_fault_i, i_fault_i}));

endmodule

// ==== pma_top.sv ====
`timescale 1ns/1ps

`include "pma_defines.svh"

module pma_top (
  input  logic                        CLK,
  input  logic                        nRST,
  // CSR port
  input  logic [11:0]                 csr_addr_i,
  input  logic                        csr_wen_i,
  input  logic [31:0]                 csr_wdata_i,
  output logic                        csr_ack_o,
  output logic [31:0]                 csr_rdata_o,
  // Data access
  input  logic [31:0]                 daddr_i,
  input  logic                        d_ren_i,
  input  logic                        d_wen_i,
  input  pma_access_pkg::acc_width_t  d_width_i,
  // Instruction fetch
  input  logic [31:0]                 iaddr_i,
  input  logic                        i_xen_i,
  input  pma_access_pkg::acc_width_t  i_width_i,
  // Exception report
  output logic                        exc_valid_o,
  output pma_access_pkg::exc_cause_t  exc_cause_o,
  output logic [31:0]                 exc_tval_o
);

  pma_cfg_pkg::pma_reg_t [`PMA_NUM_REGS-1:0] pma_regs;
  logic                                      l_fault;
  logic                                      s_fault;
  logic                                      i_fault;
  logic [31:0]                               fault_addr;

  // Configuration registers behind the CSR port
  pma_csr_regs u_regs (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_addr_i  (csr_addr_i),
    .csr_wen_i   (csr_wen_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_ack_o   (csr_ack_o),
    .csr_rdata_o (csr_rdata_o),
    .pma_regs_o  (pma_regs)
  );

  // Same-cycle fault decision
  pma_checker u_checker (
    .pma_regs_i   (pma_regs),
    .daddr_i      (daddr_i),
    .d_ren_i      (d_ren_i),
    .d_wen_i      (d_wen_i),
    .d_width_i    (d_width_i),
    .iaddr_i      (iaddr_i),
    .i_xen_i      (i_xen_i),
    .i_width_i    (i_width_i),
    .l_fault_o    (l_fault),
    .s_fault_o    (s_fault),
    .i_fault_o    (i_fault),
    .fault_addr_o (fault_addr)
  );

  // Registered exception to the core
  pma_fault_reporter u_reporter (
    .CLK          (CLK),
    .nRST         (nRST),
    .l_fault_i    (l_fault),
    .s_fault_i    (s_fault),
    .i_fault_i    (i_fault),
    .fault_addr_i (fault_addr),
    .exc_valid_o  (exc_valid_o),
    .exc_cause_o  (exc_cause_o),
    .exc_tval_o   (exc_tval_o)
  );

endmodule

// ==== src.f ====
+incdir+.
pma_access_pkg.sv
pma_cfg_pkg.sv
pma_csr_regs.sv
pma_checker.sv
pma_fault_reporter.sv
pma_top.sv
tb_pma_top.sv

// ==== tb_pma_top.sv ====
`timescale 1ns/1ps

`include "pma_defines.svh"

module tb_pma_top;

  // Test lengths, also used to size the watchdog
  localparam int N_CSR = 64;
  localparam int N_ACC = 256;
  localparam int TOTAL_CYCLES = 5 + 16 + 8 + 2 * N_CSR + N_ACC + 8;

  // Reset halves
  // Fields from bit 12 down: w r x width idm cache coh rsrv amo mem
  localparam logic [15:0] ROM_HALF = 16'h0EF1;
  localparam logic [15:0] RAM_HALF = 16'h1EF1;
  localparam logic [15:0] IO_HALF  = 16'h1E30;

  logic                       CLK;
  logic                       nRST;
  logic [11:0]                csr_addr;
  logic                       csr_wen;
  logic [31:0]                csr_wdata;
  logic                       csr_ack;
  logic [31:0]                csr_rdata;
  logic [31:0]                daddr;
  logic                       d_ren;
  logic                       d_wen;
  pma_access_pkg::acc_width_t d_width;
  logic [31:0]                iaddr;
  logic                       i_xen;
  pma_access_pkg::acc_width_t i_width;
  logic                       exc_valid;
  pma_access_pkg::exc_cause_t exc_cause;
  logic [31:0]                exc_tval;

  // Shadow registers and the registered exception model
  logic [31:0] shadow [`PMA_NUM_REGS];
  logic        m_valid;
  logic [4:0]  m_cause;
  logic [31:0] m_tval;
  integer      seed;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;

  pma_top u_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_addr_i  (csr_addr),
    .csr_wen_i   (csr_wen),
    .csr_wdata_i (csr_wdata),
    .csr_ack_o   (csr_ack),
    .csr_rdata_o (csr_rdata),
    .daddr_i     (daddr),
    .d_ren_i     (d_ren),
    .d_wen_i     (d_wen),
    .d_width_i   (d_width),
    .iaddr_i     (iaddr),
    .i_xen_i     (i_xen),
    .i_width_i   (i_width),
    .exc_valid_o (exc_valid),
    .exc_cause_o (exc_cause),
    .exc_tval_o  (exc_tval)
  );

  always #10 CLK = ~CLK;

  // Edge, then on to the drive point
  task automatic tick();
    @(posedge CLK);
    #2;
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      test_errs++;
    end
  endtask

  // WARL rule on one half
  function automatic logic [15:0] warl_fix(input logic [15:0] c);
    logic [15:0] s;
    s = c;
    // Reserved rsrv becomes none
    if (c[4:3] == 2'd3) begin
      s[4:3] = 2'd0;
    end
    // Reserved width becomes word
    if (c[9:8] == 2'd3) begin
      s[9:8] = 2'd2;
    end
    return s;
  endfunction

  // Half-region config seen by an address
  function automatic logic [15:0] half_cfg(input logic [31:0] addr);
    logic [31:0] r;
    r = shadow[addr[31:28]];
    return addr[27] ? r[31:16] : r[15:0];
  endfunction

  // One CSR cycle, ack and read data checked mid-cycle
  task automatic csr_access(input string name, input logic [11:0] addr,
                            input logic wen, input logic [31:0] data);
    logic hit;
    hit       = (addr[11:4] == `PMA_CSR_BASE);
    csr_addr  = addr;
    csr_wen   = wen;
    csr_wdata = data;
    #1;
    compare({name, " ack"}, hit, csr_ack);
    if (hit && !wen) begin
      compare({name, " rdata"}, shadow[addr[3:0]], csr_rdata);
    end
    // Write lands at the coming edge
    if (hit && wen) begin
      shadow[addr[3:0]] = {warl_fix(data[31:16]), warl_fix(data[15:0])};
    end
    tick();
    csr_wen = 1'b0;
  endtask

  // One access cycle, report checked one cycle later
  task automatic apply_access(input string name, input logic [31:0] da, input logic ren,
                              input logic wen, input logic [1:0] dw, input logic [31:0] ia,
                              input logic xen, input logic [1:0] iw);
    logic [15:0] dc;
    logic [15:0] ic;
    logic        lf;
    logic        sf;
    logic        xf;
    dc = half_cfg(da);
    ic = half_cfg(ia);
    lf = ren && (!dc[11] || (dw > dc[9:8]));
    sf = wen && (!dc[12] || (dw > dc[9:8]));
    xf = xen && (!ic[10] || (iw > ic[9:8]));
    daddr   = da;
    d_ren   = ren;
    d_wen   = wen;
    d_width = pma_access_pkg::acc_width_t'(dw);
    iaddr   = ia;
    i_xen   = xen;
    i_width = pma_access_pkg::acc_width_t'(iw);
    tick();
    // Load over store over fetch, cause and tval hold otherwise
    m_valid = lf || sf || xf;
    if (lf) begin
      m_cause = 5'd5;
      m_tval  = da;
    end else if (sf) begin
      m_cause = 5'd7;
      m_tval  = da;
    end else if (xf) begin
      m_cause = 5'd1;
      m_tval  = ia;
    end
    compare({name, " exc_valid"}, m_valid, exc_valid);
    compare({name, " exc_cause"}, m_cause, exc_cause);
    compare({name, " exc_tval"}, m_tval, exc_tval);
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      $display("Test %s: PASS", name);
      pass_cnt++;
    end else begin
      $display("Test %s: FAIL with %0d mismatches", name, test_errs);
      fail_cnt++;
    end
    test_errs = 0;
  endtask

  // Watchdog
  initial begin
    #(TOTAL_CYCLES * 20 + 1000);
    $display("Timeout: tests did not finish within %0d cycles", TOTAL_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] wd;
    logic [31:0] da;
    logic [31:0] ia;
    logic [11:0] addr;
    seed      = 32'h44efa278;
    test_errs = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    CLK       = 1'b0;
    nRST      = 1'b0;
    csr_addr  = 12'd0;
    csr_wen   = 1'b0;
    csr_wdata = 32'd0;
    daddr     = 32'd0;
    d_ren     = 1'b0;
    d_wen     = 1'b0;
    d_width   = pma_access_pkg::byte_acc;
    iaddr     = 32'd0;
    i_xen     = 1'b0;
    i_width   = pma_access_pkg::byte_acc;
    m_valid   = 1'b0;
    m_cause   = 5'd0;
    m_tval    = 32'd0;
    // Reset map, ROM low half of region 0, RAM up to 7, I/O above
    for (int i = 0; i < `PMA_NUM_REGS; i++) begin
      if (i == 0) begin
        shadow[i] = {RAM_HALF, ROM_HALF};
      end else if (i < 8) begin
        shadow[i] = {RAM_HALF, RAM_HALF};
      end else begin
        shadow[i] = {IO_HALF, IO_HALF};
      end
    end
    repeat (4) @(posedge CLK);
    #2;
    nRST = 1'b1;
    tick();

    compare("reset exc_valid", 1'b0, exc_valid);
    compare("reset exc_cause", 5'd0, exc_cause);
    compare("reset exc_tval", 32'd0, exc_tval);
    for (int i = 0; i < `PMA_NUM_REGS; i++) begin
      csr_access("reset_map", {`PMA_CSR_BASE, 4'(i)}, 1'b0, 32'd0);
    end
    end_test("reset_map");

    // Reserved encodings in one half at a time, then both
    csr_access("warl hi rsrv", {`PMA_CSR_BASE, 4'h5}, 1'b1, {RAM_HALF | 16'h0018, RAM_HALF});
    csr_access("warl hi rsrv", {`PMA_CSR_BASE, 4'h5}, 1'b0, 32'd0);
    csr_access("warl lo width", {`PMA_CSR_BASE, 4'h5}, 1'b1, {RAM_HALF, RAM_HALF | 16'h0300});
    csr_access("warl lo width", {`PMA_CSR_BASE, 4'h5}, 1'b0, 32'd0);
    csr_access("warl hi both", {`PMA_CSR_BASE, 4'h6}, 1'b1, {RAM_HALF | 16'h0318, IO_HALF});
    csr_access("warl hi both", {`PMA_CSR_BASE, 4'h6}, 1'b0, 32'd0);
    csr_access("warl lo all", {`PMA_CSR_BASE, 4'h6}, 1'b1, {IO_HALF, 16'hFFFF});
    csr_access("warl lo all", {`PMA_CSR_BASE, 4'h6}, 1'b0, 32'd0);
    end_test("warl");

    // About a quarter of the addresses miss the block
    for (int n = 0; n < N_CSR; n++) begin
      r    = $random(seed);
      wd   = $random(seed);
      addr = (r[1:0] == 2'd0) ? r[13:2] : {`PMA_CSR_BASE, r[5:2]};
      csr_access("csr_random write", addr, 1'b1, wd);
      csr_access("csr_random readback", {`PMA_CSR_BASE, addr[3:0]}, 1'b0, 32'd0);
    end
    end_test("csr_random");

    for (int n = 0; n < N_ACC; n++) begin
      r  = $random(seed);
      da = $random(seed);
      ia = $random(seed);
      apply_access("access_random", da, r[0], r[1], r[3:2], ia, r[4], r[6:5]);
    end
    end_test("access_random");

    // Region 9 with no rights, every port faults at once
    csr_access("priority setup", {`PMA_CSR_BASE, 4'h9}, 1'b1, 32'h0);
    for (int n = 0; n < 4; n++) begin
      r  = $random(seed);
      wd = $random(seed);
      da = {4'h9, r[27:0]};
      ia = {4'h9, wd[27:0]};
      apply_access("priority", da, 1'b1, 1'b1, 2'd2, ia, 1'b1, 2'd2);
      compare("priority load cause", 5'd5, exc_cause);
      compare("priority load tval", da, exc_tval);
    end
    // Idle cycles, report must hold
    for (int n = 0; n < 3; n++) begin
      apply_access("hold", 32'd0, 1'b0, 1'b0, 2'd0, 32'd0, 1'b0, 2'd0);
    end
    end_test("priority_hold");

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
